//--- include/frontend_params.svh
// Widths, pipeline depth, CSC coefficients and clamp limits for the video frontend
`ifndef FRONTEND_PARAMS_SVH
`define FRONTEND_PARAMS_SVH

// Colour component width
`define FE_PIX_W 8

// Horizontal counter width
`define FE_HCNT_W 12

// Vertical counter and position width
`define FE_VCNT_W 11

// Input to output latency in pixel clocks
`define FE_PIPE_DEPTH 5

// CSC coefficient width and chroma offset
`define FE_COEF_W 18
`define FE_CSC_OFFSET 128

// BT.601 coefficients, Q15
`define FE_COEF_601_RCR 18'h0B395
`define FE_COEF_601_GCB 18'h02C08
`define FE_COEF_601_GCR 18'h05B64
`define FE_COEF_601_BCB 18'h0E2F1

// BT.709 coefficients, Q15
`define FE_COEF_709_RCR 18'h0C8F9
`define FE_COEF_709_GCB 18'h017EF
`define FE_COEF_709_GCR 18'h03BB2
`define FE_COEF_709_BCB 18'h0ED84

// Output range of a converted component
`define FE_CLAMP_MIN 0
`define FE_CLAMP_MAX 255

`endif

//--- logic/video_pkg.sv
// Pixel, position and sync record types carried down the video pipeline
`default_nettype none

`include "frontend_params.svh"

package video_pkg;

    // One colour component
    typedef logic [`FE_PIX_W-1:0] pixel_t;

    // Horizontal count
    typedef logic [`FE_HCNT_W-1:0] hpos_t;

    // Vertical count, also used for active-area positions
    typedef logic [`FE_VCNT_W-1:0] vpos_t;

    // Three components, input carries Cr/Y/Cb in r/g/b
    typedef struct packed {
        pixel_t r;
        pixel_t g;
        pixel_t b;
    } rgb_t;

    // Regenerated sync, low-active hsync/vsync
    typedef struct packed {
        logic  hsync;
        logic  vsync;
        logic  de;
        vpos_t xpos;
        vpos_t ypos;
        logic  sof;
    } sync_t;

endpackage

`default_nettype wire

//--- logic/config_pkg.sv
// Configuration types: input timing description and colour space selection
`default_nettype none

package config_pkg;

    // Programmed input timing, in pixel clocks and lines
    typedef struct packed {
        logic [7:0]       h_synclen;
        logic [8:0]       h_backporch;
        video_pkg::hpos_t h_active;
        logic [3:0]       v_synclen;
        logic [8:0]       v_backporch;
        video_pkg::vpos_t v_active;
        // Line on which the scaler start pulse fires
        video_pkg::vpos_t v_sof_line;
    } timing_cfg_t;

    // YCbCr matrix selection
    typedef enum logic {
        CSC_601 = 1'b0,
        CSC_709 = 1'b1
    } csc_mode_e;

endpackage

`default_nettype wire

//--- logic/sync_regen.sv
// Sync regeneration: polarity normalization, h/v counters, sync/DE/position and delay line
`timescale 1ns/10ps
`default_nettype none

`include "frontend_params.svh"

module sync_regen (
    input  wire                          PCLK_i,
    input  wire                          rst_i,
    input  wire                          hs_i,
    input  wire                          vs_i,
    input  wire                          hs_pol_i,
    input  wire                          vs_pol_i,
    input  wire config_pkg::timing_cfg_t timing_cfg_i,
    output video_pkg::sync_t             sync_o
);

    // Spans one bit wider than the counters so offset plus size cannot wrap
    typedef logic [`FE_HCNT_W:0] hspan_t;
    typedef logic [`FE_VCNT_W:0] vspan_t;

    logic             hs_act;
    logic             vs_act;
    logic             hs_act_q;
    logic             vs_act_q;
    logic             h_edge;
    logic             v_edge;
    logic             line_pend;
    video_pkg::hpos_t h_cnt;
    video_pkg::vpos_t v_cnt;
    video_pkg::vpos_t v_next;
    video_pkg::hpos_t h_start;
    hspan_t           h_end;
    video_pkg::vpos_t v_start;
    vspan_t           v_end;
    video_pkg::hpos_t x_full;
    video_pkg::vpos_t y_full;
    logic             hsync_q;
    logic             vsync_q;
    logic             de_q;
    logic             sof_q;
    video_pkg::vpos_t xpos_q;
    video_pkg::vpos_t ypos_q;
    video_pkg::sync_t stage1;
    video_pkg::sync_t dly_q [`FE_PIPE_DEPTH-1];

    // Normalized syncs are high while active
    assign hs_act = hs_i ~^ hs_pol_i;
    assign vs_act = vs_i ~^ vs_pol_i;

    // Leading edge: active to inactive
    assign h_edge = hs_act_q & ~hs_act;
    assign v_edge = vs_act_q & ~vs_act;

    // Active window bounds
    assign h_start = video_pkg::hpos_t'(timing_cfg_i.h_synclen)
                   + video_pkg::hpos_t'(timing_cfg_i.h_backporch);
    assign h_end   = hspan_t'(h_start) + hspan_t'(timing_cfg_i.h_active);
    assign v_start = video_pkg::vpos_t'(timing_cfg_i.v_synclen)
                   + video_pkg::vpos_t'(timing_cfg_i.v_backporch);
    assign v_end   = vspan_t'(v_start) + vspan_t'(timing_cfg_i.v_active);

    assign x_full = h_cnt - h_start;
    assign y_full = v_cnt - v_start;

    // Line count after the coming line edge
    // Starting at 1 makes up for the line lost to vsync detection
    assign v_next = line_pend ? video_pkg::vpos_t'(1) : v_cnt + 1'b1;

    always_ff @(posedge PCLK_i) begin
        if (rst_i) begin
            hs_act_q  <= 1'b0;
            vs_act_q  <= 1'b0;
            h_cnt     <= '0;
            v_cnt     <= '0;
            line_pend <= 1'b0;
            hsync_q   <= 1'b0;
            vsync_q   <= 1'b0;
            de_q      <= 1'b0;
            sof_q     <= 1'b0;
        end else begin
            hs_act_q <= hs_act;
            vs_act_q <= vs_act;

            de_q <= (h_cnt >= h_start) && (hspan_t'(h_cnt) < h_end)
                 && (v_cnt >= v_start) && (vspan_t'(v_cnt) < v_end);

            if (h_edge) begin
                h_cnt   <= '0;
                hsync_q <= 1'b0;
                v_cnt   <= v_next;
                // Held for the whole line whose count matches
                sof_q   <= (v_next == timing_cfg_i.v_sof_line);
                if (line_pend) begin
                    vsync_q <= 1'b0;
                end else if (v_cnt == video_pkg::vpos_t'(timing_cfg_i.v_synclen) - 1'b1) begin
                    vsync_q <= 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
                if (h_cnt == video_pkg::hpos_t'(timing_cfg_i.h_synclen) - 1'b1) begin
                    hsync_q <= 1'b1;
                end
            end

            // Frame edge waits for the next line edge
            if (v_edge) begin
                line_pend <= 1'b1;
            end else if (h_edge) begin
                line_pend <= 1'b0;
            end
        end
    end

    // Positions relative to the active window, truncated
    always_ff @(posedge PCLK_i) begin
        xpos_q <= x_full[`FE_VCNT_W-1:0];
        ypos_q <= y_full;
    end

    assign stage1 = '{
        hsync: hsync_q,
        vsync: vsync_q,
        de:    de_q,
        xpos:  xpos_q,
        ypos:  ypos_q,
        sof:   sof_q
    };

    // Remaining stages to line up with the colour pipeline
    always_ff @(posedge PCLK_i) begin
        if (rst_i) begin
            for (int i = 0; i < `FE_PIPE_DEPTH-1; i++) begin
                dly_q[i] <= '0;
            end
        end else begin
            dly_q[0] <= stage1;
            for (int i = 1; i < `FE_PIPE_DEPTH-1; i++) begin
                dly_q[i] <= dly_q[i-1];
            end
        end
    end

    assign sync_o = dly_q[`FE_PIPE_DEPTH-2];

endmodule

`default_nettype wire

//--- logic/csc_ycbcr_rgb.sv
// Five-stage YCbCr to RGB matrix with BT.601/BT.709 selection, clamping and bypass
`timescale 1ns/10ps
`default_nettype none

`include "frontend_params.svh"

module csc_ycbcr_rgb (
    input  wire                        PCLK_i,
    input  wire                        rst_i,
    input  wire                        csc_en_i,
    input  wire config_pkg::csc_mode_e csc_mode_i,
    input  wire video_pkg::rgb_t       video_i,
    output video_pkg::rgb_t            video_o
);

    // Three guard bits cover sign and overflow of the sums
    localparam int SUM_W  = `FE_PIX_W + 3;
    localparam int PROD_W = SUM_W + `FE_COEF_W;
    localparam int FRAC_W = 15;

    typedef logic signed [SUM_W-1:0]      sum_t;
    typedef logic signed [`FE_COEF_W-1:0] coef_t;
    typedef logic signed [PROD_W-1:0]     prod_t;

    video_pkg::rgb_t byp_q [`FE_PIPE_DEPTH-1];
    sum_t            y2_q;
    sum_t            cb2_q;
    sum_t            cr2_q;
    coef_t           rcr_coef_q;
    coef_t           gcb_coef_q;
    coef_t           gcr_coef_q;
    coef_t           bcb_coef_q;
    prod_t           rcr_prod;
    prod_t           gcb_prod;
    prod_t           gcr_prod;
    prod_t           bcb_prod;
    sum_t            y3_q;
    sum_t            rcr3_q;
    sum_t            gcb3_q;
    sum_t            gcr3_q;
    sum_t            bcb3_q;
    sum_t            r_sum;
    sum_t            g_sum;
    sum_t            b_sum;
    video_pkg::rgb_t rgb4_q;

    function automatic video_pkg::pixel_t clamp_pix(input sum_t s);
        if (s < 0) begin
            return video_pkg::pixel_t'(`FE_CLAMP_MIN);
        end else if (s > `FE_CLAMP_MAX) begin
            return video_pkg::pixel_t'(`FE_CLAMP_MAX);
        end
        return s[`FE_PIX_W-1:0];
    endfunction

    // Stage 1 input register, then the bypass delay line
    always_ff @(posedge PCLK_i) begin
        byp_q[0] <= video_i;
        for (int i = 1; i < `FE_PIPE_DEPTH-1; i++) begin
            byp_q[i] <= byp_q[i-1];
        end
    end

    assign rcr_prod = cr2_q * rcr_coef_q;
    assign gcb_prod = cb2_q * gcb_coef_q;
    assign gcr_prod = cr2_q * gcr_coef_q;
    assign bcb_prod = cb2_q * bcb_coef_q;

    assign r_sum = y3_q + rcr3_q;
    assign g_sum = y3_q - gcb3_q - gcr3_q;
    assign b_sum = y3_q + bcb3_q;

    // Matrix stages hold when conversion is off
    always_ff @(posedge PCLK_i) begin
        if (csc_en_i) begin
            // Stage 2: Y from g, chroma made signed
            y2_q  <= sum_t'(byp_q[0].g);
            cb2_q <= sum_t'(byp_q[0].b) - sum_t'(`FE_CSC_OFFSET);
            cr2_q <= sum_t'(byp_q[0].r) - sum_t'(`FE_CSC_OFFSET);
            if (csc_mode_i == config_pkg::CSC_709) begin
                rcr_coef_q <= `FE_COEF_709_RCR;
                gcb_coef_q <= `FE_COEF_709_GCB;
                gcr_coef_q <= `FE_COEF_709_GCR;
                bcb_coef_q <= `FE_COEF_709_BCB;
            end else begin
                rcr_coef_q <= `FE_COEF_601_RCR;
                gcb_coef_q <= `FE_COEF_601_GCB;
                gcr_coef_q <= `FE_COEF_601_GCR;
                bcb_coef_q <= `FE_COEF_601_BCB;
            end

            // Stage 3: products back to integer scale
            y3_q   <= y2_q;
            rcr3_q <= rcr_prod[FRAC_W+SUM_W-1:FRAC_W];
            gcb3_q <= gcb_prod[FRAC_W+SUM_W-1:FRAC_W];
            gcr3_q <= gcr_prod[FRAC_W+SUM_W-1:FRAC_W];
            bcb3_q <= bcb_prod[FRAC_W+SUM_W-1:FRAC_W];

            // Stage 4: sums limited to the pixel range
            rgb4_q.r <= clamp_pix(r_sum);
            rgb4_q.g <= clamp_pix(g_sum);
            rgb4_q.b <= clamp_pix(b_sum);
        end
    end

    // Stage 5: converted or delayed input
    always_ff @(posedge PCLK_i) begin
        if (rst_i) begin
            video_o <= '0;
        end else if (csc_en_i) begin
            video_o <= rgb4_q;
        end else begin
            video_o <= byp_q[`FE_PIPE_DEPTH-2];
        end
    end

endmodule

`default_nettype wire

//--- logic/video_frontend.sv
// Pixel-clock video frontend top level: sync regeneration and colour space conversion
`timescale 1ns/10ps
`default_nettype none

module video_frontend (
    input  wire                          PCLK_i,
    input  wire                          rst_i,
    input  wire video_pkg::rgb_t         video_i,
    input  wire                          hs_i,
    input  wire                          vs_i,
    input  wire                          hs_pol_i,
    input  wire                          vs_pol_i,
    input  wire config_pkg::timing_cfg_t timing_cfg_i,
    input  wire                          csc_en_i,
    input  wire config_pkg::csc_mode_e   csc_mode_i,
    output video_pkg::rgb_t              video_o,
    output video_pkg::sync_t             sync_o
);

    // Sync, DE and positions, delayed to match the pixel path
    sync_regen u_sync_regen (
        .PCLK_i       (PCLK_i),
        .rst_i        (rst_i),
        .hs_i         (hs_i),
        .vs_i         (vs_i),
        .hs_pol_i     (hs_pol_i),
        .vs_pol_i     (vs_pol_i),
        .timing_cfg_i (timing_cfg_i),
        .sync_o       (sync_o)
    );

    // Pixel path, same latency with or without conversion
    csc_ycbcr_rgb u_csc (
        .PCLK_i     (PCLK_i),
        .rst_i      (rst_i),
        .csc_en_i   (csc_en_i),
        .csc_mode_i (csc_mode_i),
        .video_i    (video_i),
        .video_o    (video_o)
    );

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
// Testbench pixel clock and power-on reset generator
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        rst_o = 1'b1;
        // Reset held for two pixel clocks
        repeat (2) @(posedge clk_o);
        #2;
        rst_o = 1'b0;
    end

    // 20 ns period
    always #10 clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- test/video_frontend_assert.sv
// Concurrent assertions on the frontend sync outputs, bound to the top level
`timescale 1ns/10ps
`default_nettype none

module video_frontend_assert (
    input wire                   PCLK_i,
    input wire                   rst_i,
    input wire video_pkg::sync_t sync_i
);

    // Outputs are idle in the cycle after reset
    property p_idle_after_reset;
        @(posedge PCLK_i) $past(rst_i) |->
            (!sync_i.hsync && !sync_i.vsync && !sync_i.de && !sync_i.sof);
    endproperty

    // DE starts only after the sync pulse of its line
    property p_de_after_hsync;
        @(posedge PCLK_i) disable iff (rst_i)
            $rose(sync_i.de) |-> sync_i.hsync;
    endproperty

    // sof drops before the following line starts
    property p_sof_one_line;
        @(posedge PCLK_i) disable iff (rst_i)
            ($fell(sync_i.hsync) && sync_i.sof) |-> !$past(sync_i.sof);
    endproperty

    a_idle_after_reset: assert property (p_idle_after_reset)
        else $error("sync outputs active right after reset");
    a_de_after_hsync: assert property (p_de_after_hsync)
        else $error("de rose while hsync was low");
    a_sof_one_line: assert property (p_sof_one_line)
        else $error("sof stayed high for more than one line");

endmodule

bind video_frontend video_frontend_assert u_assert (
    .PCLK_i (PCLK_i),
    .rst_i  (rst_i),
    .sync_i (sync_o)
);

`default_nettype wire

//--- test/video_frontend_tb.sv
// Testbench for the video frontend: bypass, BT.601/BT.709 vectors and sync frame checks
`timescale 1ns/10ps
`default_nettype none

`include "frontend_params.svh"

module video_frontend_tb;

    // Synthetic input geometry
    localparam int LINE_LEN    = 80;
    localparam int FRAME_LINES = 20;
    localparam int HS_IN_W     = 6;
    localparam int VS_IN_LINES = 2;
    localparam int NUM_FRAMES  = 4;
    localparam int BYP_N       = 64;

    logic                    pclk;
    logic                    rst;
    video_pkg::rgb_t         video_in;
    video_pkg::rgb_t         video_out;
    logic                    hs_in;
    logic                    vs_in;
    logic                    hs_pol;
    logic                    vs_pol;
    config_pkg::timing_cfg_t cfg;
    logic                    csc_en;
    config_pkg::csc_mode_e   csc_mode;
    video_pkg::sync_t        sync_out;

    logic [31:0]     lfsr_state = 32'h8771c04b;
    bit              fail_shown = 0;
    bit              pass_shown = 0;
    int              budget     = 0;
    video_pkg::rgb_t stim_q[$];
    video_pkg::rgb_t exp_q[$];
    int              vec_mode[$];
    video_pkg::rgb_t vec_in[$];
    video_pkg::rgb_t vec_exp[$];

    tb_clock_gen u_clk (
        .clk_o (pclk),
        .rst_o (rst)
    );

    video_frontend dut (
        .PCLK_i       (pclk),
        .rst_i        (rst),
        .video_i      (video_in),
        .hs_i         (hs_in),
        .vs_i         (vs_in),
        .hs_pol_i     (hs_pol),
        .vs_pol_i     (vs_pol),
        .timing_cfg_i (cfg),
        .csc_en_i     (csc_en),
        .csc_mode_i   (csc_mode),
        .video_o      (video_out),
        .sync_o       (sync_out)
    );

    function automatic void note_failure();
        if (!fail_shown) begin
            $display("*** TEST FAILED ***");
            fail_shown = 1;
        end
    endfunction

    task automatic expect_equal(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("** Error: %s expected %0d actual %0d", name, expected, actual);
            note_failure();
            $fatal(1, "value mismatch");
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic read_cases();
        int              fd;
        string           line;
        int              a;
        int              b;
        int              c;
        int              d;
        int              e;
        int              f;
        int              g;
        video_pkg::rgb_t pix_in;
        video_pkg::rgb_t pix_exp;
        fd = $fopen("test/frontend_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the cases file test/frontend_cases.txt");
            note_failure();
            $fatal(1, "missing cases file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == 8'h23) begin
                continue;
            end
            if (line.getc(0) == 8'h54) begin
                void'($sscanf(line, "T %d %d %d %d %d %d %d", a, b, c, d, e, f, g));
                cfg = '{h_synclen: a, h_backporch: b, h_active: c, v_synclen: d,
                        v_backporch: e, v_active: f, v_sof_line: g};
            end else if (line.getc(0) == 8'h56) begin
                void'($sscanf(line, "V %d %d %d %d %d %d %d", a, b, c, d, e, f, g));
                vec_mode.push_back(a);
                // Cr, Y, Cb travel in the r, g, b slots
                pix_in.r  = video_pkg::pixel_t'(d);
                pix_in.g  = video_pkg::pixel_t'(b);
                pix_in.b  = video_pkg::pixel_t'(c);
                pix_exp.r = video_pkg::pixel_t'(e);
                pix_exp.g = video_pkg::pixel_t'(f);
                pix_exp.b = video_pkg::pixel_t'(g);
                vec_in.push_back(pix_in);
                vec_exp.push_back(pix_exp);
            end
        end
        $fclose(fd);
    endtask

    // Drive stim_q one sample per clock, output checked five clocks later
    task automatic play_and_check(input string name);
        int n;
        n = stim_q.size();
        for (int t = 0; t < n + `FE_PIPE_DEPTH; t++) begin
            @(posedge pclk);
            #1;
            if (t >= `FE_PIPE_DEPTH) begin
                expect_equal($sformatf("%s[%0d]", name, t - `FE_PIPE_DEPTH),
                             exp_q[t - `FE_PIPE_DEPTH], video_out);
            end
            #1;
            if (t < n) begin
                video_in = stim_q[t];
            end
        end
        stim_q.delete();
        exp_q.delete();
    endtask

    task automatic run_vectors(input string name, input int mode);
        csc_en   = 1'b1;
        csc_mode = config_pkg::csc_mode_e'(mode);
        for (int i = 0; i < vec_in.size(); i++) begin
            if (vec_mode[i] == mode) begin
                stim_q.push_back(vec_in[i]);
                exp_q.push_back(vec_exp[i]);
            end
        end
        if (stim_q.size() == 0) begin
            $display("No %s vectors found in the cases file", name);
            note_failure();
            $fatal(1, "no vectors");
        end
        play_and_check(name);
    endtask

    // Sync pulses at line start, vsync over the first lines of each frame
    task automatic drive_frames(input logic pol);
        hs_pol = pol;
        vs_pol = pol;
        for (int fr = 0; fr < NUM_FRAMES; fr++) begin
            for (int ln = 0; ln < FRAME_LINES; ln++) begin
                for (int px = 0; px < LINE_LEN; px++) begin
                    hs_in    = (px < HS_IN_W) ~^ pol;
                    vs_in    = (ln < VS_IN_LINES) ~^ pol;
                    video_in = video_pkg::rgb_t'(take_bits(24));
                    @(posedge pclk);
                    #2;
                end
            end
        end
    endtask

    // Measures the output frame between the second and third vsync falls
    task automatic measure_frame(input int pol);
        video_pkg::sync_t cur;
        video_pkg::sync_t prev;
        int               falls;
        int               de_cnt;
        int               hs_run;
        int               vs_lines;
        int               sof_cycles;
        int               sof_lines;
        int               sof_hits;
        int               first_x;
        int               first_y;
        int               last_x;
        int               last_y;
        string            tag;
        tag = $sformatf("frame pol=%0d", pol);
        falls = 0;
        de_cnt = 0;
        hs_run = 0;
        vs_lines = 0;
        sof_cycles = 0;
        sof_lines = 0;
        sof_hits = 0;
        first_x = -1;
        first_y = -1;
        last_x = -1;
        last_y = -1;
        prev = sync_out;
        while (falls < 3) begin
            @(posedge pclk);
            #1;
            cur = sync_out;
            if (prev.vsync && !cur.vsync) begin
                falls++;
            end
            if (falls == 2) begin
                if (cur.de) begin
                    de_cnt++;
                    if (de_cnt == 1) begin
                        first_x = cur.xpos;
                        first_y = cur.ypos;
                    end
                    last_x = cur.xpos;
                    last_y = cur.ypos;
                end
                if (!cur.hsync) begin
                    hs_run++;
                end else if (!prev.hsync && hs_run > 0) begin
                    expect_equal({tag, " hsync width"}, cfg.h_synclen, hs_run);
                    hs_run = 0;
                end
                if (prev.hsync && !cur.hsync) begin
                    vs_lines  += !cur.vsync;
                    sof_lines += cur.sof;
                end
                sof_cycles += cur.sof;
                if (cur.sof && cur.de
                    && cur.ypos == video_pkg::vpos_t'(cfg.v_sof_line - cfg.v_synclen
                                                      - cfg.v_backporch)) begin
                    sof_hits++;
                end
            end
            prev = cur;
        end
        expect_equal({tag, " de count"}, cfg.h_active * cfg.v_active, de_cnt);
        expect_equal({tag, " first xpos"}, 0, first_x);
        expect_equal({tag, " first ypos"}, 0, first_y);
        expect_equal({tag, " last xpos"}, cfg.h_active - 1, last_x);
        expect_equal({tag, " last ypos"}, cfg.v_active - 1, last_y);
        expect_equal({tag, " vsync lines"}, cfg.v_synclen - 1, vs_lines);
        expect_equal({tag, " sof lines"}, 1, sof_lines);
        expect_equal({tag, " sof cycles"}, LINE_LEN, sof_cycles);
        expect_equal({tag, " sof line has de at sof ypos"}, 1, int'(sof_hits > 0));
    endtask

    initial begin
        video_in = '0;
        hs_in    = 1'b0;
        vs_in    = 1'b0;
        hs_pol   = 1'b1;
        vs_pol   = 1'b1;
        cfg      = '0;
        csc_en   = 1'b0;
        csc_mode = config_pkg::CSC_601;
        read_cases();
        budget = 10 + BYP_N + vec_in.size() + 3 * `FE_PIPE_DEPTH
               + 2 * NUM_FRAMES * FRAME_LINES * LINE_LEN;
        wait (!rst);
        @(posedge pclk);
        #2;

        // Bypass keeps the input unchanged
        for (int i = 0; i < BYP_N; i++) begin
            stim_q.push_back(video_pkg::rgb_t'(take_bits(24)));
            exp_q.push_back(stim_q[i]);
        end
        play_and_check("bypass");

        run_vectors("csc601", 0);
        run_vectors("csc709", 1);

        // Active-high then active-low input sync
        csc_en = 1'b0;
        for (int pol = 1; pol >= 0; pol--) begin
            fork
                drive_frames(pol[0]);
                measure_frame(pol);
            join
        end

        if (fail_shown) begin
            $fatal(1, "checks failed");
        end else begin
            pass_shown = 1;
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

    // Watchdog sized from the stimulus length
    initial begin
        wait (budget > 0);
        repeat (budget + 1000) @(posedge pclk);
        $display("Watchdog expired: the run did not finish in %0d cycles", budget + 1000);
        note_failure();
        $fatal(1, "timeout");
    end

    // Run stopped before the final verdict
    final begin
        if (!pass_shown) begin
            note_failure();
        end
    end

endmodule

`default_nettype wire

//--- video_frontend.f
+incdir+include
logic/video_pkg.sv
logic/config_pkg.sv
logic/sync_regen.sv
logic/csc_ycbcr_rgb.sv
logic/video_frontend.sv
test/tb_clock_gen.sv
test/video_frontend_assert.sv
test/video_frontend_tb.sv

//--- Makefile
TOP = video_frontend_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f video_frontend.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- test/frontend_cases.txt
# T h_synclen h_backporch h_active v_synclen v_backporch v_active v_sof_line
# V mode(0=601 1=709) Y Cb Cr expected_R expected_G expected_B, all decimal
T 8 12 40 3 4 10 9
V 0 128 128 128 128 128 128
V 0 255 255 255 255 122 255
V 0 0 0 0 0 137 0
V 0 100 90 200 201 63 32
V 1 128 128 128 128 128 128
V 1 255 255 255 255 173 255
V 1 0 0 0 0 84 0
V 1 100 90 200 213 75 29
